//--- mfrsd_pkg.sv
package mfrsd_pkg;

   // bus widths
   localparam int CPU_AW = 16;
   localparam int DW     = 8;
   localparam int MEM_AW = 24;

   // mapper ram, 16 KB blocks
   localparam int RAM_BLOCKS = 32;
   localparam int RAM_PW     = $clog2(RAM_BLOCKS);
   localparam int RAM_AW     = RAM_PW + 14;

   // flash side, offset counted in 8 KB units
   localparam int FLASH_AW = 23;
   localparam int OFS_W    = 10;
   localparam int ROM_AW   = 20;

   // regions of the flat cartridge memory
   localparam logic [MEM_AW-1:0] RAM_BASE   = 24'h000000;
   localparam logic [MEM_AW-1:0] FLASH_BASE = 24'h800000;

   // expanded slot register
   localparam logic [CPU_AW-1:0] SUBSLOT_ADDR = 16'hFFFF;

   // subslot 0 registers
   localparam logic [CPU_AW-1:0] CFG_ADDR    = 16'h7FFC;
   localparam logic [CPU_AW-1:0] OFS_LO_ADDR = 16'h7FFD;
   localparam logic [CPU_AW-1:0] OFS_HI_ADDR = 16'h7FFE;
   localparam logic [CPU_AW-1:0] MAP_ADDR    = 16'h7FFF;
   // sound chip flag, BFFE and BFFF
   localparam logic [CPU_AW-1:0] SCC_ADDR    = 16'hBFFE;

   // sd card select, 5800 and up
   localparam logic [CPU_AW-1:0] SD_SEL_ADDR = 16'h5800;

   localparam logic [DW-1:0] CFG_RESET = 8'h03;

   // subslot numbers
   localparam logic [1:0] SUB_CFG  = 2'd0;
   localparam logic [1:0] SUB_RAM  = 2'd1;
   localparam logic [1:0] SUB_ROM  = 2'd2;
   localparam logic [1:0] SUB_NONE = 2'd3;

   // ram page registers on io ports FC-FF
   localparam logic [7:0] RAM_PORT_BASE = 8'hFC;

endpackage

//--- mfrsd_control.sv
`timescale 1ns/1ps

module mfrsd_control (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             cs,
   input  logic [1:0]                       slot,
   input  logic [mfrsd_pkg::CPU_AW-1:0]     addr,
   input  logic [mfrsd_pkg::DW-1:0]         din,
   input  logic                             rd,
   input  logic                             wr,
   input  logic                             iorq,
   input  logic [mfrsd_pkg::RAM_AW-1:0]     ram_addr,
   input  logic [mfrsd_pkg::DW-1:0]         io_dout,
   input  logic                             io_hit,
   input  logic [mfrsd_pkg::ROM_AW-1:0]     rom_addr,
   input  logic                             rom_valid,
   input  logic                             sd_data_en,
   input  logic [mfrsd_pkg::DW-1:0]         rom_dout,
   output logic                             ram_cs,
   output logic                             rom_cs,
   output logic [mfrsd_pkg::OFS_W-1:0]      ofs,
   output logic [mfrsd_pkg::MEM_AW-1:0]     mem_addr,
   output logic                             mem_unmapped,
   output logic [mfrsd_pkg::DW-1:0]         dout,
   output logic [3:0]                       mapper_mask,
   output logic                             scc_enable
);

   import mfrsd_pkg::*;

   logic [DW-1:0]       subslot_reg;
   logic [DW-1:0]       cfg_reg;
   logic [DW-1:0]       map_reg;
   logic [OFS_W-1:0]    ofs_reg;
   logic [1:0]          sub;
   logic                mem_acc;
   logic                ss_hit;
   logic                cfg_wr;
   logic [FLASH_AW-1:0] flash_ofs;

   // memory cycle in our primary slot
   assign mem_acc = cs & ~iorq;
   assign ss_hit  = addr == SUBSLOT_ADDR;

   // two register bits per 16 KB page
   assign sub = subslot_reg[{addr[15:14], 1'b0} +: 2];

   // the FFFF register hides whatever subslot sits behind it
   assign ram_cs = mem_acc & ~ss_hit & (sub == SUB_RAM);
   assign rom_cs = mem_acc & ~ss_hit & (sub == SUB_ROM);
   assign cfg_wr = mem_acc & ~ss_hit & wr & (sub == SUB_CFG);

   assign ofs = ofs_reg;

   always_ff @(posedge clk) begin
      if (reset) begin
         subslot_reg <= '0;
      end else if (mem_acc & wr & ss_hit) begin
         subslot_reg <= din;
      end
   end

   // configuration, offset and mapper registers with their locks
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_reg     <= CFG_RESET;
         map_reg     <= '0;
         ofs_reg     <= '0;
         mapper_mask <= 4'b1111;
         scc_enable  <= 1'b0;
      end else if (cfg_wr) begin
         case (addr)
            CFG_ADDR: begin
               if (~cfg_reg[7]) begin
                  cfg_reg           <= din;
                  mapper_mask[slot] <= ~din[2];
               end
            end
            OFS_LO_ADDR: begin
               if (~map_reg[1]) begin
                  ofs_reg[7:0] <= din;
               end
            end
            OFS_HI_ADDR: begin
               if (~map_reg[1]) begin
                  ofs_reg[OFS_W-1:8] <= din[OFS_W-9:0];
               end
            end
            MAP_ADDR: begin
               if (~map_reg[2]) begin
                  map_reg <= din;
               end
            end
            default: begin
               // BFFE or BFFF
               if (addr[15:1] == SCC_ADDR[15:1] && map_reg[7:5] == 3'd0) begin
                  scc_enable <= din[5];
               end
            end
         endcase
      end
   end

   // flash offset wraps inside the flash region
   assign flash_ofs = FLASH_AW'(rom_addr) + {ofs_reg, 13'd0};

   always_comb begin
      if (ram_cs) begin
         mem_addr = RAM_BASE + MEM_AW'(ram_addr);
      end else begin
         mem_addr = FLASH_BASE + MEM_AW'(flash_ofs);
      end
   end

   // subslot 0 has no memory behind its registers
   assign mem_unmapped = (mem_acc & ~ss_hit & (sub == SUB_CFG || sub == SUB_NONE))
                       | (rom_cs & ~rom_valid)
                       | sd_data_en;

   always_comb begin
      if (mem_acc & rd & ss_hit) begin
         // expanded slot register reads back inverted
         dout = ~subslot_reg;
      end else if (io_hit) begin
         dout = io_dout;
      end else begin
         dout = rom_dout;
      end
   end

   // sd data reads only come from the rom subslot
   a_sd_in_rom: assert property (@(posedge clk) disable iff (reset)
      sd_data_en |-> rom_cs);

endmodule

//--- mfrsd_ram_mapper.sv
`timescale 1ns/1ps

module mfrsd_ram_mapper (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [mfrsd_pkg::CPU_AW-1:0]     addr,
   input  logic [mfrsd_pkg::DW-1:0]         din,
   input  logic                             rd,
   input  logic                             wr,
   input  logic                             iorq,
   input  logic                             ram_cs,
   output logic [mfrsd_pkg::RAM_AW-1:0]     ram_addr,
   output logic [mfrsd_pkg::DW-1:0]         io_dout,
   output logic                             io_hit
);

   import mfrsd_pkg::*;

   logic [RAM_PW-1:0] page_reg [4];
   logic              port_hit;
   logic [RAM_PW-1:0] cur_page;

   // ports FC-FF, only the low address byte counts
   assign port_hit = addr[7:2] == RAM_PORT_BASE[7:2];
   assign io_hit   = iorq & rd & port_hit;

   always_ff @(posedge clk) begin
      if (reset) begin
         page_reg[0] <= '0;
         page_reg[1] <= '0;
         page_reg[2] <= '0;
         page_reg[3] <= '0;
      end else if (iorq & wr & port_hit) begin
         // only 32 blocks, upper bits dropped
         page_reg[addr[1:0]] <= din[RAM_PW-1:0];
      end
   end

   // unused bits of the page register read as ones
   assign io_dout = {{(DW-RAM_PW){1'b1}}, page_reg[addr[1:0]]};

   assign cur_page = page_reg[addr[15:14]];

   always_comb begin
      if (ram_cs) begin
         ram_addr = {cur_page, addr[13:0]};
      end else begin
         ram_addr = '0;
      end
   end

   // a port read never overlaps a ram access
   a_io_not_mem: assert property (@(posedge clk) disable iff (reset)
      !(io_hit && ram_cs));

endmodule

//--- mfrsd_rom_mapper.sv
`timescale 1ns/1ps

module mfrsd_rom_mapper (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             rom_cs,
   input  logic [mfrsd_pkg::CPU_AW-1:0]     addr,
   input  logic [mfrsd_pkg::DW-1:0]         din,
   input  logic                             rd,
   input  logic                             wr,
   input  logic [mfrsd_pkg::DW-1:0]         d_from_sd,
   output logic [mfrsd_pkg::ROM_AW-1:0]     rom_addr,
   output logic                             rom_valid,
   output logic                             sd_data_en,
   output logic [mfrsd_pkg::DW-1:0]         rom_dout,
   output logic                             sd_rx,
   output logic                             sd_tx
);

   import mfrsd_pkg::*;

   logic [DW-1:0] bank [4];
   logic [1:0]    page;
   logic          bank_wr;
   logic          sd_en;
   logic          sd_sel_hit;
   logic          card_sel;
   logic          rd_q;
   logic          wr_q;
   logic          rd_rise;
   logic          wr_rise;

   // bank registers live at 6000-7FFF
   assign bank_wr = rom_cs & wr & (addr[15:13] == 3'b011);

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'd0;
         bank[1] <= 8'd1;
         bank[2] <= 8'd0;
         bank[3] <= 8'd0;
      end else if (bank_wr) begin
         bank[addr[12:11]] <= din;
      end
   end

   // 4000 -> 0, 6000 -> 1, 8000 -> 2, A000 -> 3
   assign page = {~addr[14], addr[13]};

   assign rom_addr  = {bank[page][6:0], addr[12:0]};
   assign rom_valid = addr[15] ^ addr[14];

   // sd window over 4000-5FFF when bank 0 is 01xxxxxx
   assign sd_en      = rom_cs & (bank[0][7:6] == 2'b01) & (addr[15:13] == 3'b010);
   assign sd_data_en = sd_en & rd;
   assign sd_sel_hit = addr[15:11] == SD_SEL_ADDR[15:11];

   // data byte only in the lower 4 KB of the window
   assign rom_dout = (sd_data_en & ~addr[12]) ? d_from_sd : 8'hFF;

   assign rd_rise = rd & ~rd_q;
   assign wr_rise = wr & ~wr_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_q     <= 1'b0;
         wr_q     <= 1'b0;
         card_sel <= 1'b0;
         sd_rx    <= 1'b0;
         sd_tx    <= 1'b0;
      end else begin
         rd_q  <= rd;
         wr_q  <= wr;
         sd_rx <= sd_en & rd_rise & ~addr[12] & ~card_sel;
         sd_tx <= 1'b0;
         if (sd_en & wr) begin
            if (sd_sel_hit) begin
               card_sel <= din[0];
            end else if (wr_rise & ~addr[12]) begin
               // transmit only with card 0 selected
               sd_tx <= ~card_sel;
            end
         end
      end
   end

   a_sd_excl: assert property (@(posedge clk) disable iff (reset)
      !(sd_rx && sd_tx));

endmodule

//--- mfrsd_top.sv
`timescale 1ns/1ps

module mfrsd_top (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             cs,
   input  logic [1:0]                       slot,
   input  logic [mfrsd_pkg::CPU_AW-1:0]     addr,
   input  logic [mfrsd_pkg::DW-1:0]         din,
   input  logic                             rd,
   input  logic                             wr,
   input  logic                             iorq,
   input  logic [mfrsd_pkg::DW-1:0]         d_from_sd,
   output logic [mfrsd_pkg::MEM_AW-1:0]     mem_addr,
   output logic                             mem_unmapped,
   output logic [mfrsd_pkg::DW-1:0]         dout,
   output logic [3:0]                       mapper_mask,
   output logic                             scc_enable,
   output logic                             sd_rx,
   output logic                             sd_tx
);

   import mfrsd_pkg::*;

   logic              ram_cs;
   logic              rom_cs;
   logic [RAM_AW-1:0] ram_addr;
   logic [DW-1:0]     io_dout;
   logic              io_hit;
   logic [ROM_AW-1:0] rom_addr;
   logic              rom_valid;
   logic              sd_data_en;
   logic [DW-1:0]     rom_dout;

   mfrsd_control u_control (
      .clk          (clk),
      .reset        (reset),
      .cs           (cs),
      .slot         (slot),
      .addr         (addr),
      .din          (din),
      .rd           (rd),
      .wr           (wr),
      .iorq         (iorq),
      .ram_addr     (ram_addr),
      .io_dout      (io_dout),
      .io_hit       (io_hit),
      .rom_addr     (rom_addr),
      .rom_valid    (rom_valid),
      .sd_data_en   (sd_data_en),
      .rom_dout     (rom_dout),
      .ram_cs       (ram_cs),
      .rom_cs       (rom_cs),
      .ofs          (),
      .mem_addr     (mem_addr),
      .mem_unmapped (mem_unmapped),
      .dout         (dout),
      .mapper_mask  (mapper_mask),
      .scc_enable   (scc_enable)
   );

   // subslot 1, memory mapper ram
   mfrsd_ram_mapper u_ram_mapper (
      .clk      (clk),
      .reset    (reset),
      .addr     (addr),
      .din      (din),
      .rd       (rd),
      .wr       (wr),
      .iorq     (iorq),
      .ram_cs   (ram_cs),
      .ram_addr (ram_addr),
      .io_dout  (io_dout),
      .io_hit   (io_hit)
   );

   // subslot 2, banked flash and sd window
   mfrsd_rom_mapper u_rom_mapper (
      .clk        (clk),
      .reset      (reset),
      .rom_cs     (rom_cs),
      .addr       (addr),
      .din        (din),
      .rd         (rd),
      .wr         (wr),
      .d_from_sd  (d_from_sd),
      .rom_addr   (rom_addr),
      .rom_valid  (rom_valid),
      .sd_data_en (sd_data_en),
      .rom_dout   (rom_dout),
      .sd_rx      (sd_rx),
      .sd_tx      (sd_tx)
   );

endmodule

//--- tb_mfrsd.sv
`timescale 1ns/1ps

module tb_mfrsd;

   import mfrsd_pkg::*;

   logic        clk;
   logic        reset;
   logic        cs;
   logic [1:0]  slot;
   logic [15:0] addr;
   logic [7:0]  din;
   logic        rd;
   logic        wr;
   logic        iorq;
   logic [7:0]  d_from_sd;
   logic [23:0] mem_addr;
   logic        mem_unmapped;
   logic [7:0]  dout;
   logic [3:0]  mapper_mask;
   logic        scc_enable;
   logic        sd_rx;
   logic        sd_tx;

   // shadow copy of the cartridge registers
   logic [7:0]  m_ss;
   logic [7:0]  m_cfg;
   logic [7:0]  m_map;
   logic [9:0]  m_ofs;
   logic [3:0]  m_mask;
   logic        m_scc;
   logic [4:0]  m_page [4];
   logic [7:0]  m_bank [4];

   int          rx_count;
   int          tx_count;
   integer      seed;

   mfrsd_top DUT (
      .clk          (clk),
      .reset        (reset),
      .cs           (cs),
      .slot         (slot),
      .addr         (addr),
      .din          (din),
      .rd           (rd),
      .wr           (wr),
      .iorq         (iorq),
      .d_from_sd    (d_from_sd),
      .mem_addr     (mem_addr),
      .mem_unmapped (mem_unmapped),
      .dout         (dout),
      .mapper_mask  (mapper_mask),
      .scc_enable   (scc_enable),
      .sd_rx        (sd_rx),
      .sd_tx        (sd_tx)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // subslot of the 16 KB page that holds a
   function automatic logic [1:0] page_subslot(input logic [7:0] ss, input logic [15:0] a);
      case (a[15:14])
         2'd0: return ss[1:0];
         2'd1: return ss[3:2];
         2'd2: return ss[5:4];
         default: return ss[7:6];
      endcase
   endfunction

   function automatic logic sd_read_active(input logic [15:0] a, input logic mem,
                                           input logic r);
      return mem && r && a != SUBSLOT_ADDR && page_subslot(m_ss, a) == SUB_ROM
         && m_bank[0][7:6] == 2'b01 && a >= 16'h4000 && a <= 16'h5FFF;
   endfunction

   function automatic logic [23:0] flat_address(input logic [15:0] a, input logic mem);
      logic [2:0]  t;
      logic [1:0]  pg;
      logic [22:0] fofs;
      if (mem && a != SUBSLOT_ADDR && page_subslot(m_ss, a) == SUB_RAM) begin
         return RAM_BASE + {5'd0, m_page[a[15:14]], a[13:0]};
      end
      // 8 KB page counted from 4000, wraps outside the rom range
      t = a[15:13] - 3'd2;
      pg = t[1:0];
      fofs = {3'd0, m_bank[pg][6:0], a[12:0]} + {m_ofs, 13'd0};
      return FLASH_BASE + {1'b0, fofs};
   endfunction

   function automatic logic unmapped_level(input logic [15:0] a, input logic mem,
                                           input logic r);
      logic [1:0] sub;
      logic       vis;
      sub = page_subslot(m_ss, a);
      vis = mem && a != SUBSLOT_ADDR;
      if (vis && (sub == SUB_CFG || sub == 2'd3)) begin
         return 1'b1;
      end
      if (vis && sub == SUB_ROM && (a < 16'h4000 || a >= 16'hC000)) begin
         return 1'b1;
      end
      return sd_read_active(a, mem, r);
   endfunction

   function automatic logic [7:0] read_data(input logic [15:0] a, input logic mem,
                                            input logic io, input logic r,
                                            input logic [7:0] sd_byte);
      if (mem && r && a == SUBSLOT_ADDR) begin
         return ~m_ss;
      end
      if (io && r && a[7:0] >= RAM_PORT_BASE) begin
         return {3'b111, m_page[a[1:0]]};
      end
      if (sd_read_active(a, mem, r) && a < 16'h5000) begin
         return sd_byte;
      end
      return 8'hFF;
   endfunction

   function automatic logic [7:0] keep_if_locked(input logic [7:0] old_v,
                                                 input logic [7:0] new_v, input logic lock);
      return lock ? old_v : new_v;
   endfunction

   // outputs are stable at the falling edge, inputs were driven on the rising one
   always @(negedge clk) begin : compare
      logic        mem;
      logic [23:0] exp_addr;
      logic        exp_unm;
      logic [7:0]  exp_dout;
      logic [7:0]  t;
      if (reset) begin
         m_ss = 8'h00;
         m_cfg = CFG_RESET;
         m_map = 8'h00;
         m_ofs = 10'd0;
         m_mask = 4'b1111;
         m_scc = 1'b0;
         m_page = '{5'd0, 5'd0, 5'd0, 5'd0};
         m_bank = '{8'd0, 8'd1, 8'd0, 8'd0};
      end else begin
         mem = cs && !iorq;
         exp_addr = flat_address(addr, mem);
         exp_unm = unmapped_level(addr, mem, rd);
         exp_dout = read_data(addr, mem, iorq, rd, d_from_sd);
         assert (mem_addr === exp_addr) else abort_run($sformatf(
            "[FAIL] %0t ns: mem_addr %h, expected %h at addr %h",
            $time, mem_addr, exp_addr, addr));
         assert (mem_unmapped === exp_unm) else abort_run($sformatf(
            "[FAIL] %0t ns: mem_unmapped %b, expected %b at addr %h",
            $time, mem_unmapped, exp_unm, addr));
         assert (dout === exp_dout) else abort_run($sformatf(
            "[FAIL] %0t ns: dout %h, expected %h at addr %h", $time, dout, exp_dout, addr));
         assert (mapper_mask === m_mask) else abort_run($sformatf(
            "[FAIL] %0t ns: mapper_mask %b, expected %b", $time, mapper_mask, m_mask));
         assert (scc_enable === m_scc) else abort_run($sformatf(
            "[FAIL] %0t ns: scc_enable %b, expected %b", $time, scc_enable, m_scc));
         if (sd_rx) begin
            rx_count++;
         end
         if (sd_tx) begin
            tx_count++;
         end
         // register updates the DUT takes on the next rising edge
         if (mem && wr && addr == SUBSLOT_ADDR) begin
            m_ss = din;
         end else if (mem && wr && page_subslot(m_ss, addr) == SUB_CFG) begin
            if (addr == CFG_ADDR && !m_cfg[7]) begin
               m_mask[slot] = ~din[2];
               m_cfg = din;
            end else if (addr == OFS_LO_ADDR) begin
               m_ofs[7:0] = keep_if_locked(m_ofs[7:0], din, m_map[1]);
            end else if (addr == OFS_HI_ADDR) begin
               t = keep_if_locked({6'd0, m_ofs[9:8]}, din, m_map[1]);
               m_ofs[9:8] = t[1:0];
            end else if (addr == MAP_ADDR) begin
               m_map = keep_if_locked(m_map, din, m_map[2]);
            end else if ((addr == 16'hBFFE || addr == 16'hBFFF) && m_map[7:5] == 3'd0) begin
               m_scc = din[5];
            end
         end else if (mem && wr && page_subslot(m_ss, addr) == SUB_ROM
                      && addr[15:13] == 3'b011) begin
            m_bank[addr[12:11]] = din;
         end
         if (iorq && wr && addr[7:0] >= RAM_PORT_BASE) begin
            m_page[addr[1:0]] = din[4:0];
         end
      end
   end

   task automatic drive_bus(input logic c, input logic io, input logic [15:0] a,
                            input logic [7:0] d, input logic r, input logic w,
                            input logic [1:0] s);
      logic [31:0] rnd;
      rnd = $random(seed);
      @(posedge clk);
      cs <= c;
      iorq <= io;
      addr <= a;
      din <= d;
      rd <= r;
      wr <= w;
      slot <= s;
      d_from_sd <= rnd[7:0];
   endtask

   task automatic store_byte(input logic [15:0] a, input logic [7:0] d);
      drive_bus(1'b1, 1'b0, a, d, 1'b0, 1'b1, 2'd0);
   endtask

   task automatic fetch_byte(input logic [15:0] a);
      drive_bus(1'b1, 1'b0, a, 8'h00, 1'b1, 1'b0, 2'd0);
   endtask

   task automatic write_config(input logic [1:0] s, input logic [7:0] d);
      drive_bus(1'b1, 1'b0, CFG_ADDR, d, 1'b0, 1'b1, s);
   endtask

   task automatic port_write(input logic [15:0] a, input logic [7:0] d);
      drive_bus(1'b0, 1'b1, a, d, 1'b0, 1'b1, 2'd0);
   endtask

   task automatic port_read(input logic [15:0] a);
      drive_bus(1'b0, 1'b1, a, 8'h00, 1'b1, 1'b0, 2'd0);
   endtask

   task automatic idle_cycle();
      logic [31:0] rnd;
      rnd = $random(seed);
      drive_bus(1'b0, 1'b0, rnd[15:0], rnd[23:16], 1'b0, 1'b0, 2'd0);
   endtask

   // counts falling edges until the pulse shows up
   task automatic wait_pulse(input logic tx, input int limit, output int waited);
      int n;
      n = 0;
      waited = -1;
      while (waited < 0) begin
         @(negedge clk);
         n++;
         if ((tx ? sd_tx : sd_rx) === 1'b1) begin
            waited = n;
         end else if (n >= limit) begin
            abort_run($sformatf("timeout: no %s pulse within %0d cycles",
                                tx ? "sd_tx" : "sd_rx", limit));
         end
      end
   endtask

   initial begin : stimulus
      int          waited;
      int          rx_before;
      int          tx_before;
      logic [31:0] r;
      logic [7:0]  v;
      logic [1:0]  s;
      seed = 32'h4ec3;
      rx_count = 0;
      tx_count = 0;
      reset = 1'b1;
      cs = 1'b0;
      slot = 2'd0;
      addr = 16'h0000;
      din = 8'h00;
      rd = 1'b0;
      wr = 1'b0;
      iorq = 1'b0;
      d_from_sd = 8'h00;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // reset state
      fetch_byte(SUBSLOT_ADDR);
      @(negedge clk);
      assert (dout === 8'hFF && mapper_mask === 4'b1111 && scc_enable === 1'b0)
         else abort_run($sformatf("[FAIL] %0t ns: reset state dout %h mask %b scc %b",
                                  $time, dout, mapper_mask, scc_enable));
      fetch_byte(16'h4000);
      @(negedge clk);
      assert (mem_unmapped === 1'b1)
         else abort_run($sformatf("[FAIL] %0t ns: subslot 0 read not unmapped", $time));

      // expanded slot register
      repeat (24) begin
         v = $random(seed);
         store_byte(SUBSLOT_ADDR, v);
         fetch_byte(SUBSLOT_ADDR);
         @(negedge clk);
         assert (dout === ~v)
            else abort_run($sformatf("[FAIL] %0t ns: FFFF read %h after writing %h",
                                     $time, dout, v));
         for (int p = 0; p < 4; p++) begin
            r = $random(seed);
            fetch_byte({p[1:0], r[13:0]});
         end
      end

      // ram page registers, then subslot 1 everywhere
      repeat (16) begin
         r = $random(seed);
         v = r[31:24];
         port_write({r[15:8], 6'b111111, r[1:0]}, v);
         port_read({r[23:16], 6'b111111, r[1:0]});
         @(negedge clk);
         assert (dout === {3'b111, v[4:0]})
            else abort_run($sformatf("[FAIL] %0t ns: port read %h after writing %h",
                                     $time, dout, v));
      end
      store_byte(SUBSLOT_ADDR, 8'h55);
      repeat (32) begin
         r = $random(seed);
         fetch_byte(r[15:0]);
      end

      // config register and its lock, sound chip flag
      store_byte(SUBSLOT_ADDR, 8'h00);
      repeat (8) begin
         r = $random(seed);
         s = r[1:0];
         v = r[15:8] & 8'h7F;
         write_config(s, v);
         idle_cycle();
         @(negedge clk);
         assert (mapper_mask[s] === ~v[2])
            else abort_run($sformatf("[FAIL] %0t ns: mapper_mask %b after config %h slot %0d",
                                     $time, mapper_mask, v, s));
      end
      write_config(2'd1, 8'h84);
      write_config(2'd1, 8'h00);
      idle_cycle();
      @(negedge clk);
      assert (mapper_mask[1] === 1'b0)
         else abort_run($sformatf("[FAIL] %0t ns: locked config still changed the mask", $time));
      store_byte(16'hBFFE, 8'h20);
      store_byte(MAP_ADDR, 8'hE0);
      store_byte(16'hBFFF, 8'h00);
      idle_cycle();
      @(negedge clk);
      assert (scc_enable === 1'b1)
         else abort_run($sformatf("[FAIL] %0t ns: scc_enable cleared while blocked", $time));
      store_byte(MAP_ADDR, 8'h00);
      store_byte(16'hBFFE, 8'h00);
      idle_cycle();
      @(negedge clk);
      assert (scc_enable === 1'b0)
         else abort_run($sformatf("[FAIL] %0t ns: scc_enable not cleared", $time));

      // flash banks and offset, then the offset and mapper locks
      for (int k = 0; k < 36; k++) begin
         if (k == 12) begin
            store_byte(MAP_ADDR, 8'h02);
         end
         if (k == 24) begin
            store_byte(MAP_ADDR, 8'h06);
            store_byte(MAP_ADDR, 8'h00);
         end
         r = $random(seed);
         store_byte(SUBSLOT_ADDR, 8'h28);
         store_byte({3'b011, r[12:0]}, r[31:24]);
         store_byte(SUBSLOT_ADDR, 8'h20);
         store_byte(OFS_LO_ADDR, r[23:16]);
         store_byte(OFS_HI_ADDR, r[15:8]);
         store_byte(SUBSLOT_ADDR, 8'h28);
         repeat (4) begin
            r = $random(seed);
            fetch_byte({r[15] ? 2'b10 : 2'b01, r[13:0]});
         end
      end

      // sd window with bank 0 at 01xxxxxx
      store_byte(SUBSLOT_ADDR, 8'h28);
      store_byte(16'h6000, 8'h40);
      idle_cycle();
      rx_before = rx_count;
      tx_before = tx_count;
      fetch_byte(16'h4000);
      @(negedge clk);
      assert (dout === d_from_sd)
         else abort_run($sformatf("[FAIL] %0t ns: sd read %h, card byte %h",
                                  $time, dout, d_from_sd));
      idle_cycle();
      wait_pulse(1'b0, 4, waited);
      assert (waited == 1)
         else abort_run($sformatf("[FAIL] %0t ns: sd_rx came %0d cycles late", $time, waited));
      store_byte(16'h4000, 8'h5A);
      idle_cycle();
      wait_pulse(1'b1, 4, waited);
      assert (waited == 1)
         else abort_run($sformatf("[FAIL] %0t ns: sd_tx came %0d cycles late", $time, waited));
      repeat (2) idle_cycle();
      assert (rx_count == rx_before + 1 && tx_count == tx_before + 1)
         else abort_run($sformatf("[FAIL] %0t ns: pulse counts rx %0d tx %0d",
                                  $time, rx_count - rx_before, tx_count - tx_before));

      // card 1 selected, no strobes
      store_byte(16'h5800, 8'h01);
      idle_cycle();
      fetch_byte(16'h4000);
      idle_cycle();
      store_byte(16'h4000, 8'hA5);
      repeat (4) idle_cycle();
      assert (rx_count == rx_before + 1 && tx_count == tx_before + 1)
         else abort_run($sformatf("[FAIL] %0t ns: strobe with card 1 selected", $time));

      idle_cycle();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- mfrsd_top.f
mfrsd_pkg.sv
mfrsd_control.sv
mfrsd_ram_mapper.sv
mfrsd_rom_mapper.sv
mfrsd_top.sv
tb_mfrsd.sv

//--- Bender.yml
package:
  name: mfrsd

sources:
  - mfrsd_pkg.sv
  - mfrsd_control.sv
  - mfrsd_ram_mapper.sv
  - mfrsd_rom_mapper.sv
  - mfrsd_top.sv
  - target: test
    files:
      - tb_mfrsd.sv
